/* hdl/muldiv_defs.svh */
`ifndef MULDIV_DEFS_SVH
`define MULDIV_DEFS_SVH

// data word width of the integer core
`define MULDIV_XLEN 64

// operand width of the W forms
`define MULDIV_HALF 32

// divider counter start values
// one compare step more than the quotient width, the first step is a dummy
`define MULDIV_DIV_ITER64 65
`define MULDIV_DIV_ITER32 33

`endif

/* hdl/muldiv_pkg.sv */
`default_nettype none

`include "muldiv_defs.svh"

package muldiv_pkg;

    typedef logic [`MULDIV_XLEN-1:0] word_t;

    // funct3 read as a multiply
    typedef struct packed {
        logic       is_div;
        logic [1:0] mul_sel;  // 0 mul, 1 mulh, 2 mulhsu, 3 mulhu
    } muldiv_mul_f_t;

    // funct3 read as a divide
    typedef struct packed {
        logic is_div;
        logic is_rem;
        logic is_unsigned;
    } muldiv_div_f_t;

    typedef union packed {
        logic [2:0]    raw;   // funct3 as received
        muldiv_mul_f_t mul;
        muldiv_div_f_t div;
    } muldiv_op_u;

endpackage

`default_nettype wire

/* hdl/muldiv_req_if.sv */
`timescale 1ns/100ps
`default_nettype none

interface muldiv_req_if;
    import muldiv_pkg::*;

    logic       request;  // single cycle strobe
    logic       kill;     // level, aborts work in flight
    muldiv_op_u op;
    logic       int_32;   // W form
    word_t      src1;
    word_t      src2;

    modport src (output request, kill, op, int_32, src1, src2);

    modport eng (input request, kill, op, int_32, src1, src2);

    // selector only needs the op for formatting
    modport sel (input request, kill, op, int_32);

endinterface

`default_nettype wire

/* hdl/div_unit.sv */
`timescale 1ns/100ps
`default_nettype none

`include "muldiv_defs.svh"

module div_unit (
    input  wire logic          clk_i,
    input  wire logic          rstn_i,
    muldiv_req_if.eng          req,
    output muldiv_pkg::word_t  quo_o,
    output muldiv_pkg::word_t  rmd_o,
    output logic               done_o,
    output logic               stall_o
);
    import muldiv_pkg::*;

    localparam int X     = `MULDIV_XLEN;
    localparam int H     = `MULDIV_HALF;
    localparam int CNT_W = $clog2(`MULDIV_DIV_ITER64 + 1);

    localparam logic [1:0] st_idle = 2'd0;
    localparam logic [1:0] st_iter = 2'd1;
    localparam logic [1:0] st_last = 2'd2;
    localparam logic [1:0] st_done = 2'd3;

    logic [1:0]       state_q, state_d;
    logic [CNT_W-1:0] cnt_q, cnt_d;
    word_t            rh_q, rh_d;       // partial remainder
    word_t            rl_q, rl_d;       // dividend in, quotient out
    word_t            dsor_q, dsor_d;
    word_t            dvnd_q;           // raw dividend for divide by zero
    logic             dz_q;
    logic             neg_quo_q;
    logic             neg_rmd_q;

    logic  start;
    logic  signed_op;
    logic  a_neg, b_neg;
    word_t a_abs, b_abs;
    logic  div_zero;
    word_t rh_tmp;
    logic  q_bit;

    // operand preparation, only meaningful in the start cycle
    assign signed_op = ~req.op.div.is_unsigned;
    assign a_neg     = signed_op & (req.int_32 ? req.src1[H-1] : req.src1[X-1]);
    assign b_neg     = signed_op & (req.int_32 ? req.src2[H-1] : req.src2[X-1]);
    assign a_abs     = a_neg ? -req.src1 : req.src1;
    assign b_abs     = b_neg ? -req.src2 : req.src2;
    assign div_zero  = req.int_32 ? (req.src2[H-1:0] == '0) : (req.src2 == '0);

    assign start = (state_q == st_idle) & req.request & req.op.div.is_div & ~req.kill;

    // compare and subtract
    always_comb begin
        if (rh_q >= dsor_q) begin
            rh_tmp = rh_q - dsor_q;
            q_bit  = 1'b1;
        end else begin
            rh_tmp = rh_q;
            q_bit  = 1'b0;
        end
    end

    always_comb begin
        state_d = state_q;
        cnt_d   = cnt_q;
        rh_d    = rh_q;
        rl_d    = rl_q;
        dsor_d  = dsor_q;
        stall_o = 1'b0;
        done_o  = 1'b0;
        case (state_q)
            st_idle: begin
                if (start) begin
                    stall_o = 1'b1;
                    rh_d    = '0;
                    rl_d    = req.int_32 ? {a_abs[H-1:0], {(X-H){1'b0}}} : a_abs;
                    dsor_d  = req.int_32 ? {{(X-H){1'b0}}, b_abs[H-1:0]} : b_abs;
                    cnt_d   = req.int_32 ? CNT_W'(`MULDIV_DIV_ITER32)
                                         : CNT_W'(`MULDIV_DIV_ITER64);
                    state_d = st_iter;
                end
            end
            st_iter: begin
                stall_o = 1'b1;  // busy until kill takes effect
                if (req.kill) begin
                    state_d = st_idle;
                end else begin
                    rl_d  = {rl_q[X-2:0], q_bit};
                    rh_d  = {rh_tmp[X-2:0], rl_q[X-1]};  // shift both halves left
                    cnt_d = cnt_q - 1'b1;
                    if (cnt_q == CNT_W'(2))
                        state_d = st_last;
                end
            end
            st_last: begin
                stall_o = 1'b1;
                if (req.kill) begin
                    state_d = st_idle;
                end else begin
                    rl_d    = {rl_q[X-2:0], q_bit};
                    rh_d    = rh_tmp;                   // final remainder, no shift
                    state_d = st_done;
                end
            end
            st_done: begin
                done_o  = ~req.kill;
                state_d = st_idle;
            end
            default: state_d = st_idle;
        endcase
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            state_q <= st_idle;
            cnt_q   <= '0;
        end else begin
            state_q <= state_d;
            cnt_q   <= cnt_d;
        end
    end

    always_ff @(posedge clk_i) begin
        rh_q   <= rh_d;
        rl_q   <= rl_d;
        dsor_q <= dsor_d;
        if (start) begin
            dvnd_q    <= req.src1;
            dz_q      <= div_zero;
            neg_quo_q <= a_neg ^ b_neg;
            neg_rmd_q <= a_neg;  // remainder follows the dividend
        end
    end

    // riscv rules, divide by zero wins over sign correction
    assign quo_o = dz_q ? '1 : (neg_quo_q ? -rl_q : rl_q);
    assign rmd_o = dz_q ? dvnd_q : (neg_rmd_q ? -rh_q : rh_q);

endmodule

`default_nettype wire

/* hdl/mul_unit.sv */
`timescale 1ns/100ps
`default_nettype none

`include "muldiv_defs.svh"

module mul_unit (
    input  wire logic          clk_i,
    input  wire logic          rstn_i,
    muldiv_req_if.eng          req,
    output muldiv_pkg::word_t  prod_hi_o,
    output muldiv_pkg::word_t  prod_lo_o,
    output logic               done_o
);
    import muldiv_pkg::*;

    localparam int X = `MULDIV_XLEN;
    localparam int H = `MULDIV_HALF;

    logic       start;
    logic [1:0] mul_sel;
    logic       sa, sb;     // operand treated as signed
    word_t      opa, opb;
    logic       neg_a, neg_b;
    word_t      corr;

    // stage 1 registers
    logic  v1_q;
    word_t pp_ll_q, pp_lh_q, pp_hl_q, pp_hh_q;
    word_t corr_q;

    // stage 2 registers
    logic             v2_q;
    logic [2*X-1:0]   prod_sum;
    logic [2*X-1:0]   prod_q;

    assign start   = req.request & ~req.kill & ~req.op.mul.is_div;
    assign mul_sel = req.op.mul.mul_sel;

    assign sa = (mul_sel == 2'd1) | (mul_sel == 2'd2);  // mulh, mulhsu
    assign sb = (mul_sel == 2'd1);

    // W forms widen from bit 31 first
    assign opa = req.int_32 ? {{(X-H){sa & req.src1[H-1]}}, req.src1[H-1:0]} : req.src1;
    assign opb = req.int_32 ? {{(X-H){sb & req.src2[H-1]}}, req.src2[H-1:0]} : req.src2;

    assign neg_a = sa & opa[X-1];
    assign neg_b = sb & opb[X-1];

    // unsigned product minus this term, shifted up by X, gives the signed product
    assign corr = (neg_a ? opb : '0) + (neg_b ? opa : '0);

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            v1_q <= 1'b0;
            v2_q <= 1'b0;
        end else begin
            v1_q <= start;
            v2_q <= v1_q & ~req.kill;  // flush on kill
        end
    end

    always_ff @(posedge clk_i) begin
        if (start) begin
            pp_ll_q <= X'(opa[H-1:0]) * X'(opb[H-1:0]);
            pp_lh_q <= X'(opa[H-1:0]) * X'(opb[X-1:H]);
            pp_hl_q <= X'(opa[X-1:H]) * X'(opb[H-1:0]);
            pp_hh_q <= X'(opa[X-1:H]) * X'(opb[X-1:H]);
            corr_q  <= corr;
        end
    end

    // stage 2 adds the cross terms in the middle
    assign prod_sum = {pp_hh_q, pp_ll_q}
                    + {{H{1'b0}}, pp_lh_q, {H{1'b0}}}
                    + {{H{1'b0}}, pp_hl_q, {H{1'b0}}}
                    - {corr_q, {X{1'b0}}};

    always_ff @(posedge clk_i) begin
        if (v1_q)
            prod_q <= prod_sum;
    end

    assign prod_hi_o = prod_q[2*X-1:X];
    assign prod_lo_o = prod_q[X-1:0];
    assign done_o    = v2_q;

endmodule

`default_nettype wire

/* hdl/muldiv_result_sel.sv */
`timescale 1ns/100ps
`default_nettype none

`include "muldiv_defs.svh"

module muldiv_result_sel (
    input  wire logic                clk_i,
    input  wire logic                rstn_i,
    muldiv_req_if.sel                req,
    input  wire muldiv_pkg::word_t   quo_i,
    input  wire muldiv_pkg::word_t   rmd_i,
    input  wire muldiv_pkg::word_t   prod_hi_i,
    input  wire muldiv_pkg::word_t   prod_lo_i,
    input  wire logic                div_done_i,
    input  wire logic                mul_done_i,
    output muldiv_pkg::word_t        result_o,
    output logic                     done_o
);
    import muldiv_pkg::*;

    localparam int X = `MULDIV_XLEN;
    localparam int H = `MULDIV_HALF;

    // one entry per multiplier stage, head matches mul_done_i
    muldiv_op_u mq_op_q [2];
    logic [1:0] mq_w_q;
    muldiv_op_u dv_op_q;   // divide slot
    logic       dv_w_q;

    word_t pick;
    logic  w;
    word_t fmt;
    word_t result_q;
    logic  done_q;

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            mq_op_q[0] <= '0;
            mq_op_q[1] <= '0;
            mq_w_q     <= '0;
            dv_op_q    <= '0;
            dv_w_q     <= 1'b0;
        end else if (req.kill) begin
            mq_op_q[0] <= '0;
            mq_op_q[1] <= '0;
            mq_w_q     <= '0;
            dv_op_q    <= '0;
            dv_w_q     <= 1'b0;
        end else begin
            mq_op_q[0] <= req.op;
            mq_op_q[1] <= mq_op_q[0];
            mq_w_q     <= {mq_w_q[0], req.int_32};
            if (req.request) begin  // no request arrives while a divide runs
                dv_op_q <= req.op;
                dv_w_q  <= req.int_32;
            end
        end
    end

    always_comb begin
        pick = '0;
        w    = 1'b0;
        if (div_done_i) begin
            pick = dv_op_q.div.is_rem ? rmd_i : quo_i;
            w    = dv_w_q;
        end else if (mul_done_i) begin
            w = mq_w_q[1];
            if (mq_op_q[1].mul.mul_sel == 2'd0)
                pick = prod_lo_i;
            else if (w)
                pick = {{(X-H){1'b0}}, prod_lo_i[X-1:H]};  // upper half of 64-bit product
            else
                pick = prod_hi_i;
        end
        fmt = w ? {{(X-H){pick[H-1]}}, pick[H-1:0]} : pick;
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            result_q <= '0;
            done_q   <= 1'b0;
        end else begin
            done_q <= (div_done_i | mul_done_i) & ~req.kill;
            if ((div_done_i | mul_done_i) & ~req.kill)
                result_q <= fmt;  // held until the next done
        end
    end

    assign result_o = result_q;
    assign done_o   = done_q;

endmodule

`default_nettype wire

/* hdl/muldiv_unit.sv */
`timescale 1ns/100ps
`default_nettype none

module muldiv_unit (
    input  wire logic                clk_i,
    input  wire logic                rstn_i,
    input  wire logic                request_i,
    input  wire logic                kill_i,
    input  wire logic [2:0]          op_i,      // funct3
    input  wire logic                int_32_i,
    input  wire muldiv_pkg::word_t   src1_i,
    input  wire muldiv_pkg::word_t   src2_i,
    output muldiv_pkg::word_t        result_o,
    output logic                     done_o,
    output logic                     busy_o
);
    import muldiv_pkg::*;

    word_t quo;
    word_t rmd;
    word_t prod_hi;
    word_t prod_lo;
    logic  div_done;
    logic  mul_done;

    muldiv_req_if req_bus ();

    // plain ports onto the shared request bus
    assign req_bus.request = request_i;
    assign req_bus.kill    = kill_i;
    assign req_bus.op      = op_i;
    assign req_bus.int_32  = int_32_i;
    assign req_bus.src1    = src1_i;
    assign req_bus.src2    = src2_i;

    div_unit u_div (
        .clk_i   (clk_i),
        .rstn_i  (rstn_i),
        .req     (req_bus),
        .quo_o   (quo),
        .rmd_o   (rmd),
        .done_o  (div_done),
        .stall_o (busy_o)       // only the divider holds off requests
    );

    mul_unit u_mul (
        .clk_i     (clk_i),
        .rstn_i    (rstn_i),
        .req       (req_bus),
        .prod_hi_o (prod_hi),
        .prod_lo_o (prod_lo),
        .done_o    (mul_done)
    );

    muldiv_result_sel u_sel (
        .clk_i      (clk_i),
        .rstn_i     (rstn_i),
        .req        (req_bus),
        .quo_i      (quo),
        .rmd_i      (rmd),
        .prod_hi_i  (prod_hi),
        .prod_lo_i  (prod_lo),
        .div_done_i (div_done),
        .mul_done_i (mul_done),
        .result_o   (result_o),
        .done_o     (done_o)
    );

endmodule

`default_nettype wire

/* test/tb_muldiv.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_muldiv;
    import muldiv_pkg::*;

    localparam int MUL_LAT   = 3;
    localparam int DIV64_LAT = 67;
    localparam int DIV32_LAT = 35;
    localparam int N_MUL     = 48;
    localparam int N_DIV     = 24;
    // 18 extra divide slots for corner, kill and ordering runs
    localparam int LIMIT = 20 + 3 * (N_MUL * MUL_LAT + (N_DIV + 18) * DIV64_LAT) / 2;

    logic        clk_i, rstn_i, request_i, kill_i, int_32_i, done_o, busy_o;
    logic [2:0]  op_i;
    word_t       src1_i, src2_i, result_o;
    logic [31:0] seed = 32'he34b;
    int          cyc = 0;
    int          n_checks = 0;
    int          n_err = 0;
    int          err_mark = 0;
    logic        div_active = 1'b0;
    int          div_end = 0;    // cycle where busy_o must be low again
    word_t       exp_val [$];
    int          exp_cyc [$];
    string       exp_name [$];
    string       op_names [8] = '{"mul", "mulh", "mulhsu", "mulhu",
                                  "div", "divu", "rem", "remu"};

    muldiv_unit DUT (.*);

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    function automatic logic [31:0] lcg_next();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    // a quarter of the draws are corner values
    function automatic word_t rand_word();
        logic [31:0] r;
        r = lcg_next();
        case (r[31:28])
            4'd0: return '0;
            4'd1: return '1;
            4'd2: return {1'b1, 63'd0};
            4'd3: return {lcg_next(), 32'h8000_0000};  // most negative W value
            default: return {lcg_next(), r};
        endcase
    endfunction

    // riscv M result, W forms widen the operands to 64 bits first
    function automatic word_t ref_result(input logic [2:0] op, input logic w,
                                         input word_t a, input word_t b);
        logic         sa, sb;
        word_t        ea, eb, res;
        logic [127:0] prod;
        sa   = op[2] ? ~op[0] : (op[1:0] == 2'd1 || op[1:0] == 2'd2);
        sb   = op[2] ? ~op[0] : (op[1:0] == 2'd1);
        ea   = w ? {{32{sa & a[31]}}, a[31:0]} : a;
        eb   = w ? {{32{sb & b[31]}}, b[31:0]} : b;
        prod = {{64{sa & ea[63]}}, ea} * {{64{sb & eb[63]}}, eb};
        if (!op[2])
            res = (op[1:0] == 2'd0) ? prod[63:0] : (w ? prod[63:0] >> 32 : prod[127:64]);
        else if (eb == '0)
            res = op[1] ? ea : '1;
        else if (sa && ea == {1'b1, 63'd0} && eb == '1)
            res = op[1] ? '0 : ea;   // signed overflow
        else if (!sa)
            res = op[1] ? ea % eb : ea / eb;
        else if (op[1])
            res = $signed(ea) % $signed(eb);
        else
            res = $signed(ea) / $signed(eb);
        return w ? {{32{res[31]}}, res[31:0]} : res;
    endfunction

    task automatic check(input string name, input word_t exp, input word_t act);
        n_checks++;
        if (exp !== act) begin
            n_err++;
            $display("MISMATCH %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic issue(input logic [2:0] op, input logic w, input word_t a, input word_t b);
        string nm;
        nm = w ? {op_names[op], "w"} : op_names[op];
        @(posedge clk_i);
        request_i <= 1'b1;
        op_i      <= op;
        int_32_i  <= w;
        src1_i    <= a;
        src2_i    <= b;
        exp_val.push_back(ref_result(op, w, a, b));
        exp_name.push_back(nm);
        exp_cyc.push_back(cyc + (!op[2] ? MUL_LAT : (w ? DIV32_LAT : DIV64_LAT)));
        if (op[2]) begin
            div_active = 1'b1;
            div_end    = exp_cyc[$] - 1;  // engine done cycle
        end
    endtask

    task automatic run_one(input logic [2:0] op, input logic w, input word_t a, input word_t b);
        issue(op, w, a, b);
        @(posedge clk_i) request_i <= 1'b0;
        while (exp_val.size() != 0)
            @(posedge clk_i);
    endtask

    task automatic end_test(input string name);
        $display("test %s finished with %0d errors", name, n_err - err_mark);
        err_mark = n_err;
    endtask

    // sampled mid cycle, away from the driving edge
    always @(negedge clk_i) begin
        if (cyc >= LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", LIMIT);
            $display("ERRORS FOUND");
            $finish;
        end else begin
            if (div_active) begin
                check("div busy", cyc != div_end, busy_o);
                div_active = (cyc != div_end);
            end
            if (done_o && exp_val.size() == 0) begin
                n_err++;
                $display("done_o pulsed in cycle %0d with no result outstanding", cyc);
            end else if (done_o) begin
                check(exp_name[0], exp_val.pop_front(), result_o);
                check({exp_name.pop_front(), " cycle"}, exp_cyc.pop_front(), cyc);
            end
            cyc = cyc + 1;
        end
    end

    initial begin
        logic [31:0] r;
        word_t       ovf;
        rstn_i    = 1'b0;
        request_i = 1'b0;
        kill_i    = 1'b0;
        op_i      = '0;
        int_32_i  = 1'b0;
        src1_i    = '0;
        src2_i    = '0;
        repeat (4) @(posedge clk_i);
        rstn_i <= 1'b1;
        repeat (2) begin
            @(negedge clk_i);
            check("reset busy", 0, busy_o);
            check("reset done", 0, done_o);
            check("reset result", 0, result_o);
        end
        end_test("reset");

        for (int i = 0; i < N_MUL; i++) begin
            r = lcg_next();
            issue({1'b0, r[25:24]}, r[20], rand_word(), rand_word());  // one per cycle
        end
        run_one(3'd3, 1'b0, rand_word(), rand_word());
        end_test("mul_stream");

        for (int i = 0; i < N_DIV; i++) begin
            r = lcg_next();
            run_one({1'b1, r[25:24]}, r[20], rand_word(), rand_word());
        end
        end_test("div_random");

        for (int w = 0; w < 2; w++) begin
            for (int k = 4; k < 8; k++)
                run_one(3'(k), w == 1, rand_word(), w == 1 ? {lcg_next(), 32'd0} : '0);
            ovf = w == 1 ? {lcg_next(), 32'h8000_0000} : {1'b1, 63'd0};
            run_one(3'd4, w == 1, ovf, '1);
            run_one(3'd6, w == 1, ovf, '1);
        end
        end_test("div_corner");

        issue(3'd4, 1'b0, rand_word(), rand_word());
        @(posedge clk_i) request_i <= 1'b0;
        repeat (20) @(posedge clk_i);
        kill_i <= 1'b1;
        div_active = 1'b0;
        exp_val.delete();   // killed divide must never report
        exp_cyc.delete();
        exp_name.delete();
        @(negedge clk_i);
        check("kill busy", 1, busy_o);
        @(posedge clk_i) kill_i <= 1'b0;
        @(negedge clk_i);
        check("kill busy", 0, busy_o);
        repeat (60) @(posedge clk_i);
        run_one(3'd6, 1'b0, rand_word(), rand_word());
        end_test("div_kill");

        issue(3'd5, 1'b1, rand_word(), rand_word());
        @(posedge clk_i) request_i <= 1'b0;
        do @(negedge clk_i); while (!done_o);
        issue(3'd1, 1'b0, rand_word(), rand_word());   // cycle after the divide result
        run_one(3'd7, 1'b0, rand_word(), rand_word()); // divide right behind it
        end_test("div_mul_order");

        $display("%0d checks, %0d errors", n_checks, n_err);
        if (n_err == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

endmodule

`default_nettype wire

/* flist.f */
+incdir+hdl
hdl/muldiv_pkg.sv
hdl/muldiv_req_if.sv
hdl/div_unit.sv
hdl/mul_unit.sv
hdl/muldiv_result_sel.sv
hdl/muldiv_unit.sv
test/tb_muldiv.sv
